// File: Bender.yml
package:
  name: csr_top

sources:
  - csr_pkg.sv
  - csr_exc_regs.sv
  - csr_timer.sv
  - csr_scratch_regs.sv
  - csr_read_mux.sv
  - csr_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_csr_top.sv

// File: csr_exc_regs.sv
`timescale 1ns/10ps

module csr_exc_regs import csr_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      csr_we,
    input  csr_num_t  csr_num,
    input  csr_data_t csr_wmask,
    input  csr_data_t csr_wvalue,
    input  logic      wb_ex,
    input  logic      ertn_flush,
    input  csr_data_t wb_csr_pc,
    input  csr_data_t wb_vaddr,
    input  ecode_t    wb_ecode,
    input  esubcode_t wb_esubcode,
    input  logic [7:0] hw_int_in,
    input  logic      ipi_int_in,
    input  logic      timer_int,
    output plv_t      crmd_plv,
    output logic      crmd_ie,
    output plv_t      prmd_pplv,
    output logic      prmd_pie,
    output int_vec_t  ecfg_lie,
    output int_vec_t  estat_is,
    output ecode_t    estat_ecode,
    output esubcode_t estat_esubcode,
    output csr_data_t era_pc,
    output csr_data_t badv_vaddr,
    output csr_data_t eentry_base,
    output logic      has_int
);

    csr_data_t   crmd_merge;
    csr_data_t   prmd_merge;
    csr_data_t   ecfg_merge;
    csr_data_t   estat_merge;
    csr_data_t   eentry_merge;
    logic [1:0]  swi;
    logic [7:0]  hwi;
    logic        ipi;
    logic [25:0] eentry_va;
    logic        addr_err;

    assign crmd_merge   = csr_merge({29'b0, crmd_ie, crmd_plv}, csr_wvalue, csr_wmask);
    assign prmd_merge   = csr_merge({29'b0, prmd_pie, prmd_pplv}, csr_wvalue, csr_wmask);
    assign ecfg_merge   = csr_merge({19'b0, ecfg_lie}, csr_wvalue, csr_wmask);
    assign estat_merge  = csr_merge({30'b0, swi}, csr_wvalue, csr_wmask);
    assign eentry_merge = csr_merge(eentry_base, csr_wvalue, csr_wmask);

    // ------------------------------------------------------------
    // CRMD and PRMD
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == CSR_CRMD) begin
            crmd_plv <= crmd_merge[1:0];
            crmd_ie  <= crmd_merge[IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && csr_num == CSR_PRMD) begin
            prmd_pplv <= prmd_merge[1:0];
            prmd_pie  <= prmd_merge[IE_BIT];
        end
    end

    // ------------------------------------------------------------
    // ECFG and ESTAT
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie <= '0;
            swi      <= '0;
            hwi      <= '0;
            ipi      <= 1'b0;
        end else begin
            if (csr_we && csr_num == CSR_ECFG) begin
                ecfg_lie <= ecfg_merge[12:0] & LIE_WRITABLE;
            end
            if (csr_we && csr_num == CSR_ESTAT) begin
                swi <= estat_merge[1:0];
            end
            // External lines sampled every cycle
            hwi <= hw_int_in;
            ipi <= ipi_int_in;
        end
    end

    always_comb begin
        estat_is               = '0;
        estat_is[1:0]          = swi;
        estat_is[9:2]          = hwi;
        estat_is[IS_TIMER_BIT] = timer_int;
        estat_is[IS_IPI_BIT]   = ipi;
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end
    end

    // ------------------------------------------------------------
    // ERA, BADV and EENTRY
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            era_pc <= wb_csr_pc;
        end else if (csr_we && csr_num == CSR_ERA) begin
            era_pc <= csr_merge(era_pc, csr_wvalue, csr_wmask);
        end
    end

    assign addr_err = wb_ecode == ECODE_ADE || wb_ecode == ECODE_ALE;

    always_ff @(posedge clk) begin
        if (wb_ex && addr_err) begin
            // Fetch-side ADE faults on the PC itself
            if (wb_ecode == ECODE_ADE && wb_esubcode == ESUB_ADEF) begin
                badv_vaddr <= wb_csr_pc;
            end else begin
                badv_vaddr <= wb_vaddr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (csr_we && csr_num == CSR_EENTRY) begin
            eentry_va <= eentry_merge[31:EENTRY_VA_LSB];
        end
    end

    assign eentry_base = {eentry_va, 6'b0};

    // IPI is left out of has_int
    assign has_int = crmd_ie && |(estat_is[IS_TIMER_BIT:0] & ecfg_lie[IS_TIMER_BIT:0]);

endmodule

// File: csr_pkg.sv
package csr_pkg;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------
    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;

    // ------------------------------------------------------------
    // Register numbers
    // ------------------------------------------------------------
    localparam csr_num_t CSR_CRMD   = 14'h0000;
    localparam csr_num_t CSR_PRMD   = 14'h0001;
    localparam csr_num_t CSR_ECFG   = 14'h0004;
    localparam csr_num_t CSR_ESTAT  = 14'h0005;
    localparam csr_num_t CSR_ERA    = 14'h0006;
    localparam csr_num_t CSR_BADV   = 14'h0007;
    localparam csr_num_t CSR_EENTRY = 14'h000c;
    localparam csr_num_t CSR_SAVE0  = 14'h0030;
    localparam csr_num_t CSR_SAVE1  = 14'h0031;
    localparam csr_num_t CSR_SAVE2  = 14'h0032;
    localparam csr_num_t CSR_SAVE3  = 14'h0033;
    localparam csr_num_t CSR_TID    = 14'h0040;
    localparam csr_num_t CSR_TCFG   = 14'h0041;
    localparam csr_num_t CSR_TVAL   = 14'h0042;
    localparam csr_num_t CSR_TICLR  = 14'h0044;

    // Exception codes
    localparam ecode_t    ECODE_ADE = 6'h08;
    localparam ecode_t    ECODE_ALE = 6'h09;
    localparam esubcode_t ESUB_ADEF = 9'h000;

    // ------------------------------------------------------------
    // Field positions
    // ------------------------------------------------------------
    localparam int IE_BIT            = 2;
    localparam int EENTRY_VA_LSB     = 6;
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITV_LSB    = 2;
    localparam int TICLR_CLR_BIT     = 0;
    localparam int IS_TIMER_BIT      = 11;
    localparam int IS_IPI_BIT        = 12;

    // Bit 10 is reserved in LIE
    localparam int_vec_t  LIE_WRITABLE = 13'h1bff;
    localparam csr_data_t TIMER_IDLE   = 32'hffff_ffff;

    // Mask bits set take the new value, clear keep the old one
    function automatic csr_data_t csr_merge(
        csr_data_t old_value,
        csr_data_t wvalue,
        csr_data_t wmask
    );
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage

// File: csr_read_mux.sv
`timescale 1ns/10ps

module csr_read_mux import csr_pkg::*; (
    input  csr_num_t  csr_num,
    input  plv_t      crmd_plv,
    input  logic      crmd_ie,
    input  plv_t      prmd_pplv,
    input  logic      prmd_pie,
    input  int_vec_t  ecfg_lie,
    input  int_vec_t  estat_is,
    input  ecode_t    estat_ecode,
    input  esubcode_t estat_esubcode,
    input  csr_data_t era_pc,
    input  csr_data_t badv_vaddr,
    input  csr_data_t eentry_base,
    input  csr_data_t tcfg_word,
    input  csr_data_t tval,
    input  csr_data_t save0,
    input  csr_data_t save1,
    input  csr_data_t save2,
    input  csr_data_t save3,
    input  csr_data_t tid,
    output csr_data_t csr_rvalue
);

    csr_data_t crmd_word;
    csr_data_t estat_word;

    // DATM, DATF and PG read 0, DA reads 1
    assign crmd_word  = {23'b0, 2'b00, 2'b00, 1'b0, 1'b1, crmd_ie, crmd_plv};
    assign estat_word = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};

    always_comb begin
        case (csr_num)
            CSR_CRMD:   csr_rvalue = crmd_word;
            CSR_PRMD:   csr_rvalue = {29'b0, prmd_pie, prmd_pplv};
            CSR_ECFG:   csr_rvalue = {19'b0, ecfg_lie};
            CSR_ESTAT:  csr_rvalue = estat_word;
            CSR_ERA:    csr_rvalue = era_pc;
            CSR_BADV:   csr_rvalue = badv_vaddr;
            CSR_EENTRY: csr_rvalue = eentry_base;
            CSR_SAVE0:  csr_rvalue = save0;
            CSR_SAVE1:  csr_rvalue = save1;
            CSR_SAVE2:  csr_rvalue = save2;
            CSR_SAVE3:  csr_rvalue = save3;
            CSR_TID:    csr_rvalue = tid;
            CSR_TCFG:   csr_rvalue = tcfg_word;
            CSR_TVAL:   csr_rvalue = tval;
            CSR_TICLR:  csr_rvalue = '0;
            default:    csr_rvalue = '0;
        endcase
    end

endmodule

// File: csr_scratch_regs.sv
`timescale 1ns/10ps

module csr_scratch_regs import csr_pkg::*; #(
    parameter csr_data_t CORE_ID = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      resetn,
    input  logic      csr_we,
    input  csr_num_t  csr_num,
    input  csr_data_t csr_wmask,
    input  csr_data_t csr_wvalue,
    output csr_data_t save0,
    output csr_data_t save1,
    output csr_data_t save2,
    output csr_data_t save3,
    output csr_data_t tid
);

    localparam csr_num_t SAVE_NUM [4] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3};

    csr_data_t save [4];

    for (genvar i = 0; i < 4; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (csr_we && csr_num == SAVE_NUM[i]) begin
                save[i] <= csr_merge(save[i], csr_wvalue, csr_wmask);
            end
        end
    end

    assign save0 = save[0];
    assign save1 = save[1];
    assign save2 = save[2];
    assign save3 = save[3];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tid <= CORE_ID;
        end else if (csr_we && csr_num == CSR_TID) begin
            tid <= csr_merge(tid, csr_wvalue, csr_wmask);
        end
    end

endmodule

// File: csr_timer.sv
`timescale 1ns/10ps

module csr_timer import csr_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      csr_we,
    input  csr_num_t  csr_num,
    input  csr_data_t csr_wmask,
    input  csr_data_t csr_wvalue,
    output csr_data_t tcfg_word,
    output csr_data_t tval,
    output logic      timer_int
);

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    logic        tcfg_we;
    logic        ticlr_hit;
    csr_data_t   tcfg_next;

    assign tcfg_we   = csr_we && csr_num == CSR_TCFG;
    assign ticlr_hit = csr_we && csr_num == CSR_TICLR
                       && csr_wmask[TICLR_CLR_BIT] && csr_wvalue[TICLR_CLR_BIT];

    assign tcfg_word = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_next = csr_merge(tcfg_word, csr_wvalue, csr_wmask);

    // ------------------------------------------------------------
    // TCFG fields
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg_en <= 1'b0;
        end else if (tcfg_we) begin
            tcfg_en <= tcfg_next[TCFG_EN_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_we) begin
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC_BIT];
            tcfg_initval  <= tcfg_next[31:TCFG_INITV_LSB];
        end
    end

    // ------------------------------------------------------------
    // Down-counter
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tval <= TIMER_IDLE;
        end else if (tcfg_we && tcfg_next[TCFG_EN_BIT]) begin
            // Enabling write loads on the same edge
            tval <= {tcfg_next[31:TCFG_INITV_LSB], 2'b00};
        end else if (tcfg_en && tval != TIMER_IDLE) begin
            if (tval == '0 && tcfg_periodic) begin
                tval <= {tcfg_initval, 2'b00};
            end else begin
                // One-shot wraps to idle and stops
                tval <= tval - 1'b1;
            end
        end
    end

    // Zero wins over a clear on the same edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_int <= 1'b0;
        end else if (tval == '0) begin
            timer_int <= 1'b1;
        end else if (ticlr_hit) begin
            timer_int <= 1'b0;
        end
    end

endmodule

// File: csr_top.sv
`timescale 1ns/10ps

module csr_top import csr_pkg::*; #(
    parameter csr_data_t CORE_ID = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       csr_we,
    input  csr_num_t   csr_num,
    input  csr_data_t  csr_wmask,
    input  csr_data_t  csr_wvalue,
    input  logic       wb_ex,
    input  logic       ertn_flush,
    input  csr_data_t  wb_csr_pc,
    input  csr_data_t  wb_vaddr,
    input  ecode_t     wb_ecode,
    input  esubcode_t  wb_esubcode,
    input  logic [7:0] hw_int_in,
    input  logic       ipi_int_in,
    output csr_data_t  csr_rvalue,
    output csr_data_t  ex_entry,
    output csr_data_t  ertn_entry,
    output plv_t       crmd_plv,
    output ecode_t     estat_ecode,
    output logic       has_int
);

    logic      crmd_ie;
    plv_t      prmd_pplv;
    logic      prmd_pie;
    int_vec_t  ecfg_lie;
    int_vec_t  estat_is;
    esubcode_t estat_esubcode;
    csr_data_t era_pc;
    csr_data_t badv_vaddr;
    csr_data_t eentry_base;
    csr_data_t tcfg_word;
    csr_data_t tval;
    logic      timer_int;
    csr_data_t save0;
    csr_data_t save1;
    csr_data_t save2;
    csr_data_t save3;
    csr_data_t tid;

    csr_exc_regs u_exc_regs (
        .clk            (clk),
        .resetn         (resetn),
        .csr_we         (csr_we),
        .csr_num        (csr_num),
        .csr_wmask      (csr_wmask),
        .csr_wvalue     (csr_wvalue),
        .wb_ex          (wb_ex),
        .ertn_flush     (ertn_flush),
        .wb_csr_pc      (wb_csr_pc),
        .wb_vaddr       (wb_vaddr),
        .wb_ecode       (wb_ecode),
        .wb_esubcode    (wb_esubcode),
        .hw_int_in      (hw_int_in),
        .ipi_int_in     (ipi_int_in),
        .timer_int      (timer_int),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .ecfg_lie       (ecfg_lie),
        .estat_is       (estat_is),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .era_pc         (era_pc),
        .badv_vaddr     (badv_vaddr),
        .eentry_base    (eentry_base),
        .has_int        (has_int)
    );

    csr_timer u_timer (
        .clk        (clk),
        .resetn     (resetn),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .tcfg_word  (tcfg_word),
        .tval       (tval),
        .timer_int  (timer_int)
    );

    csr_scratch_regs #(
        .CORE_ID (CORE_ID)
    ) u_scratch_regs (
        .clk        (clk),
        .resetn     (resetn),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .save0      (save0),
        .save1      (save1),
        .save2      (save2),
        .save3      (save3),
        .tid        (tid)
    );

    csr_read_mux u_read_mux (
        .csr_num        (csr_num),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .ecfg_lie       (ecfg_lie),
        .estat_is       (estat_is),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .era_pc         (era_pc),
        .badv_vaddr     (badv_vaddr),
        .eentry_base    (eentry_base),
        .tcfg_word      (tcfg_word),
        .tval           (tval),
        .save0          (save0),
        .save1          (save1),
        .save2          (save2),
        .save3          (save3),
        .tid            (tid),
        .csr_rvalue     (csr_rvalue)
    );

    // Redirect targets for the pipeline
    assign ex_entry   = eentry_base;
    assign ertn_entry = era_pc;

endmodule

// File: csr_top_input.txt
// op num mask value expected, all hex. Ops: 0 write, 1 read, 2 exception, 3 ertn, 4 int lines,
// 5 wait read, 6 check output, 7 random SAVE, 8 check SAVE, 9 wait output, f end
// Exception: num = {esubcode, ecode}, mask = PC, value = vaddr. Output num: 0 ex_entry,
// 1 ertn_entry, 2 has_int, 3 crmd_plv, 4 estat_ecode. Int lines: value[7:0] hw, value[8] ipi
// Reset values
1 0040 ffffffff 00000000 00000005
1 0000 ffffffff 00000000 00000008
1 0042 ffffffff 00000000 ffffffff
6 0002 00000000 00000000 00000000
// SAVE registers and masked writes
7 0030 00000000 00000000 00000000
7 0031 00000000 00000000 00000000
7 0032 00000000 00000000 00000000
7 0033 00000000 00000000 00000000
0 0030 0000ffff 1234abcd 00000000
0 0033 80000001 00000000 00000000
8 0030 00000000 00000000 00000000
8 0031 00000000 00000000 00000000
8 0032 00000000 00000000 00000000
8 0033 00000000 00000000 00000000
// LIE bit 10 stays zero
0 0004 ffffffff ffffffff 00000000
1 0004 ffffffff 00000000 00001bff
0 0004 ffffffff 00000000 00000000
// EENTRY drops its low six bits
0 000c ffffffff 1c00007f 00000000
1 000c ffffffff 00000000 1c000040
// ADE with ADEF, then ADE with ADEM
2 00000008 1c002000 0badf00d 00000000
1 0007 ffffffff 00000000 1c002000
2 00000048 1c002100 00c0ffee 00000000
1 0007 ffffffff 00000000 00c0ffee
// ALE entry from PLV 3 with IE set
0 0000 ffffffff 00000007 00000000
1 0000 ffffffff 00000000 0000000f
2 00000009 1c001234 0000beef 00000000
1 0000 ffffffff 00000000 00000008
1 0001 ffffffff 00000000 00000007
1 0006 ffffffff 00000000 1c001234
1 0007 ffffffff 00000000 0000beef
1 0005 7fff0000 00000000 00090000
6 0000 00000000 00000000 1c000040
// Return
3 0000 00000000 00000000 00000000
1 0000 ffffffff 00000000 0000000f
6 0001 00000000 00000000 1c001234
6 0003 00000000 00000000 00000003
// Hardware interrupt line 0 on IS bit 2
0 0004 ffffffff 00000004 00000000
4 0000 00000000 00000001 00000000
9 0002 00000000 00000000 00000001
1 0005 00001fff 00000000 00000004
0 0004 ffffffff 00000000 00000000
6 0002 00000000 00000000 00000000
4 0000 00000000 00000000 00000000
// One-shot timer, initial value 4
0 0004 ffffffff 00000800 00000000
0 0041 ffffffff 00000011 00000000
5 0005 00000800 00000000 00000800
1 0042 ffffffff 00000000 ffffffff
6 0002 00000000 00000000 00000001
0 0044 00000001 00000001 00000000
1 0005 00000800 00000000 00000000
// Periodic timer
0 0041 ffffffff 00000013 00000000
5 0005 00000800 00000000 00000800
0 0044 00000001 00000001 00000000
1 0005 00000800 00000000 00000000
5 0005 00000800 00000000 00000800
f 0000 00000000 00000000 00000000

// File: flist.f
csr_pkg.sv
csr_exc_regs.sv
csr_timer.sv
csr_scratch_regs.sv
csr_read_mux.sv
csr_top.sv
tb_clk_gen.sv
tb_csr_top.sv

// File: tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: tb_csr_top.sv
`timescale 1ns/10ps

module tb_csr_top import csr_pkg::*; ();

    localparam int MAX_OPS    = 96;
    localparam int FIELDS     = 5;
    localparam int WAIT_LIMIT = 200;

    // Operation codes of the vector file
    localparam logic [31:0] OP_WRITE      = 32'h0;
    localparam logic [31:0] OP_READ       = 32'h1;
    localparam logic [31:0] OP_EXCEPTION  = 32'h2;
    localparam logic [31:0] OP_ERTN       = 32'h3;
    localparam logic [31:0] OP_LINES      = 32'h4;
    localparam logic [31:0] OP_WAIT_READ  = 32'h5;
    localparam logic [31:0] OP_CHECK_OUT  = 32'h6;
    localparam logic [31:0] OP_RAND_SAVE  = 32'h7;
    localparam logic [31:0] OP_CHECK_SAVE = 32'h8;
    localparam logic [31:0] OP_WAIT_OUT   = 32'h9;
    localparam logic [31:0] OP_END        = 32'hf;

    logic       clk;
    logic       resetn;
    logic       csr_we;
    csr_num_t   csr_num;
    csr_data_t  csr_wmask;
    csr_data_t  csr_wvalue;
    logic       wb_ex;
    logic       ertn_flush;
    csr_data_t  wb_csr_pc;
    csr_data_t  wb_vaddr;
    ecode_t     wb_ecode;
    esubcode_t  wb_esubcode;
    logic [7:0] hw_int_in;
    logic       ipi_int_in;
    csr_data_t  csr_rvalue;
    csr_data_t  ex_entry;
    csr_data_t  ertn_entry;
    plv_t       crmd_plv;
    ecode_t     estat_ecode;
    logic       has_int;

    logic [31:0] vectors [0:MAX_OPS*FIELDS-1];
    csr_data_t   save_model [4];
    logic [31:0] rand_state;

    tb_clk_gen #(
        .PERIOD (20)
    ) u_clk_gen (
        .clk (clk)
    );

    csr_top #(
        .CORE_ID (32'h0000_0005)
    ) csr_top_inst (
        .clk         (clk),
        .resetn      (resetn),
        .csr_we      (csr_we),
        .csr_num     (csr_num),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_csr_pc   (wb_csr_pc),
        .wb_vaddr    (wb_vaddr),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry),
        .crmd_plv    (crmd_plv),
        .estat_ecode (estat_ecode),
        .has_int     (has_int)
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 0 ex_entry, 1 ertn_entry, 2 has_int, 3 crmd_plv, 4 estat_ecode
    function automatic logic [31:0] probe_output(input logic [31:0] sel);
        case (sel)
            32'd0:   return ex_entry;
            32'd1:   return ertn_entry;
            32'd2:   return {31'b0, has_int};
            32'd3:   return {30'b0, crmd_plv};
            32'd4:   return {26'b0, estat_ecode};
            default: return 'x;
        endcase
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got %08h, expected %08h",
                     $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run aborted");
    endtask

    // Strobes last one cycle unless the next operation drives them again
    task automatic begin_cycle();
        @(posedge clk);
        csr_we     <= 1'b0;
        wb_ex      <= 1'b0;
        ertn_flush <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // Vector runner
    // ------------------------------------------------------------
    initial begin
        logic [31:0] op;
        logic [31:0] num;
        logic [31:0] mask;
        logic [31:0] value;
        logic [31:0] exp_word;
        int          op_index;
        int          wait_count;
        int          save_idx;
        bit          finished;

        resetn      = 1'b0;
        csr_we      = 1'b0;
        csr_num     = '0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        ertn_flush  = 1'b0;
        wb_csr_pc   = '0;
        wb_vaddr    = '0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        rand_state  = 32'hd521_ea2a;

        $readmemh("csr_top_input.txt", vectors);

        repeat (16) @(posedge clk);
        resetn <= 1'b1;

        op_index = 0;
        finished = 1'b0;
        while (!finished) begin
            if (op_index >= MAX_OPS) begin
                abort_run("Vector file has no end marker");
            end
            op       = vectors[op_index*FIELDS];
            num      = vectors[op_index*FIELDS+1];
            mask     = vectors[op_index*FIELDS+2];
            value    = vectors[op_index*FIELDS+3];
            exp_word = vectors[op_index*FIELDS+4];
            save_idx = int'(num - CSR_SAVE0);

            begin_cycle();
            case (op)
                OP_WRITE: begin
                    csr_we     <= 1'b1;
                    csr_num    <= num[13:0];
                    csr_wmask  <= mask;
                    csr_wvalue <= value;
                    if (num >= CSR_SAVE0 && num <= CSR_SAVE3) begin
                        save_model[save_idx] = (save_model[save_idx] & ~mask) | (value & mask);
                    end
                end
                OP_READ: begin
                    csr_num <= num[13:0];
                    @(negedge clk);
                    check_equal(csr_rvalue & mask, exp_word,
                                $sformatf("op %0d read of CSR %h", op_index, num[13:0]));
                    // Ecode output port tracks the ESTAT field
                    if (num[13:0] == CSR_ESTAT && &mask[21:16]) begin
                        check_equal({26'b0, estat_ecode}, {26'b0, exp_word[21:16]},
                                    $sformatf("op %0d estat_ecode output", op_index));
                    end
                end
                OP_EXCEPTION: begin
                    wb_ex       <= 1'b1;
                    wb_ecode    <= num[5:0];
                    wb_esubcode <= num[14:6];
                    wb_csr_pc   <= mask;
                    wb_vaddr    <= value;
                end
                OP_ERTN: begin
                    ertn_flush <= 1'b1;
                end
                OP_LINES: begin
                    hw_int_in  <= value[7:0];
                    ipi_int_in <= value[8];
                end
                OP_WAIT_READ: begin
                    csr_num <= num[13:0];
                    @(negedge clk);
                    for (wait_count = 0; (csr_rvalue & mask) !== exp_word; wait_count++) begin
                        if (wait_count > WAIT_LIMIT) begin
                            abort_run($sformatf("Timed out at op %0d waiting on CSR %h",
                                                op_index, num[13:0]));
                        end
                        @(negedge clk);
                    end
                end
                OP_CHECK_OUT: begin
                    @(negedge clk);
                    check_equal(probe_output(num), exp_word,
                                $sformatf("op %0d output select %0d", op_index, num));
                end
                OP_RAND_SAVE: begin
                    rand_state = xorshift32(rand_state);
                    save_model[save_idx] = rand_state;
                    csr_we     <= 1'b1;
                    csr_num    <= num[13:0];
                    csr_wmask  <= 32'hffff_ffff;
                    csr_wvalue <= rand_state;
                end
                OP_CHECK_SAVE: begin
                    csr_num <= num[13:0];
                    @(negedge clk);
                    check_equal(csr_rvalue, save_model[save_idx],
                                $sformatf("op %0d SAVE read of CSR %h", op_index, num[13:0]));
                end
                OP_WAIT_OUT: begin
                    @(negedge clk);
                    for (wait_count = 0; probe_output(num) !== exp_word; wait_count++) begin
                        if (wait_count > WAIT_LIMIT) begin
                            abort_run($sformatf("Timed out at op %0d waiting on output %0d",
                                                op_index, num));
                        end
                        @(negedge clk);
                    end
                end
                OP_END: begin
                    finished = 1'b1;
                end
                default: begin
                    abort_run($sformatf("Unknown operation %h at op %0d", op, op_index));
                end
            endcase
            op_index++;
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
